// ==== rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;

  // major opcodes of the supported instruction kinds.
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // addi x0, x0, 0.
  localparam logic [31:0] INST_NOP = 32'h0000_0013;

  // encoded as {funct7[5], funct3}.
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word seen through each base format.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

endpackage

// ==== rv_pipe_ctrl.sv ====
module rv_pipe_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic inst_valid_i,
  input  logic ret_ready_i,
  output logic inst_ready_o,
  output logic d_load_o,
  output logic e_load_o,
  output logic d_valid_o,
  output logic e_valid_o,
  output logic retire_o
);

  // state bits are {decode full, execute full}.
  localparam logic [1:0] EMPTY = 2'b00;
  localparam logic [1:0] EXE   = 2'b01;
  localparam logic [1:0] DEC   = 2'b10;
  localparam logic [1:0] BOTH  = 2'b11;

  logic [1:0] state_q;
  logic [1:0] state_d;

  assign d_valid_o = (state_q == DEC) || (state_q == BOTH);
  assign e_valid_o = (state_q == EXE) || (state_q == BOTH);

  assign retire_o     = e_valid_o & ret_ready_i;
  assign e_load_o     = d_valid_o & (~e_valid_o | retire_o);
  assign inst_ready_o = ~d_valid_o | e_load_o;
  assign d_load_o     = inst_valid_i & inst_ready_o;

  assign state_d[1] = d_load_o | (d_valid_o & ~e_load_o);
  assign state_d[0] = e_load_o | (e_valid_o & ~retire_o);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== rv_decoder.sv ====
module rv_decoder (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    d_load_i,
  input  logic                    e_valid_i,
  input  logic [31:0]             inst_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
  output logic [4:0]              rs1_addr_o,
  output logic [4:0]              rs2_addr_o,
  input  logic [4:0]              fwd_rd_i,
  input  logic                    fwd_we_i,
  input  logic [rv_pkg::XLEN-1:0] fwd_data_i,
  output rv_pkg::alu_op_e         alu_op_o,
  output logic [rv_pkg::XLEN-1:0] op1_o,
  output logic [rv_pkg::XLEN-1:0] op2_o,
  output logic [rv_pkg::XLEN-1:0] rs1_val_o,
  output logic [rv_pkg::XLEN-1:0] rs2_val_o,
  output logic [rv_pkg::XLEN-1:0] imm_o,
  output logic [rv_pkg::XLEN-1:0] tgt_base_o,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic [4:0]              rd_o,
  output logic                    rd_we_o,
  output logic                    is_branch_o,
  output logic                    is_jump_o,
  output logic                    illegal_o,
  output logic [2:0]              funct3_o
);

  rv_pkg::inst_u                 inst_q;
  logic [rv_pkg::XLEN-1:0] pc_q;
  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic                    fwd_hit1;
  logic                    fwd_hit2;

  // the register comes out of reset holding a nop.
  always_ff @(posedge clk) begin
    if (rst) begin
      inst_q <= rv_pkg::INST_NOP;
    end else if (d_load_i) begin
      inst_q <= inst_i;
    end
  end

  always_ff @(posedge clk) begin
    if (d_load_i) begin
      pc_q <= pc_i;
    end
  end

  //////////////////////////////
  // fields and immediates.

  assign rs1_addr_o = inst_q.r.rs1;
  assign rs2_addr_o = inst_q.r.rs2;
  assign rd_o       = inst_q.r.rd;
  assign funct3_o   = inst_q.r.funct3;
  assign pc_o       = pc_q;

  assign imm_i = {{20{inst_q.i.imm_11_0[11]}}, inst_q.i.imm_11_0};
  assign imm_b = {{19{inst_q.b.imm_12}}, inst_q.b.imm_12, inst_q.b.imm_11,
                  inst_q.b.imm_10_5, inst_q.b.imm_4_1, 1'b0};
  assign imm_u = {inst_q.u.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_q.j.imm_20}}, inst_q.j.imm_20, inst_q.j.imm_19_12,
                  inst_q.j.imm_11, inst_q.j.imm_10_1, 1'b0};

  // the instruction in execute has not been written back yet.
  assign fwd_hit1 = e_valid_i & fwd_we_i & (fwd_rd_i != 5'd0) & (fwd_rd_i == inst_q.r.rs1);
  assign fwd_hit2 = e_valid_i & fwd_we_i & (fwd_rd_i != 5'd0) & (fwd_rd_i == inst_q.r.rs2);

  assign rs1_val_o = fwd_hit1 ? fwd_data_i : rs1_data_i;
  assign rs2_val_o = fwd_hit2 ? fwd_data_i : rs2_data_i;

  //////////////////////////////
  // operand selection.

  always_comb begin
    alu_op_o    = rv_pkg::ALU_ADD;
    op1_o       = '0;
    op2_o       = '0;
    imm_o       = '0;
    tgt_base_o  = pc_q;
    rd_we_o     = 1'b0;
    is_branch_o = 1'b0;
    is_jump_o   = 1'b0;
    illegal_o   = 1'b0;
    case (inst_q.r.opcode)
      rv_pkg::OP_LUI: begin
        imm_o   = imm_u;
        op2_o   = imm_u;
        rd_we_o = 1'b1;
      end
      rv_pkg::OP_AUIPC: begin
        imm_o   = imm_u;
        op1_o   = pc_q;
        op2_o   = imm_u;
        rd_we_o = 1'b1;
      end
      rv_pkg::OP_JAL: begin
        imm_o     = imm_j;
        op1_o     = pc_q;
        op2_o     = 32'd4;
        rd_we_o   = 1'b1;
        is_jump_o = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        imm_o      = imm_i;
        op1_o      = pc_q;
        op2_o      = 32'd4;
        tgt_base_o = rs1_val_o;
        rd_we_o    = 1'b1;
        is_jump_o  = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        imm_o       = imm_b;
        op1_o       = rs1_val_o;
        op2_o       = rs2_val_o;
        is_branch_o = 1'b1;
      end
      rv_pkg::OP_IMM: begin
        // only srai carries funct7[5] as part of the opcode.
        alu_op_o = rv_pkg::alu_op_e'({(inst_q.r.funct3 == 3'b101) & inst_q.r.funct7[5],
                                      inst_q.r.funct3});
        imm_o    = imm_i;
        op1_o    = rs1_val_o;
        op2_o    = imm_i;
        rd_we_o  = 1'b1;
      end
      rv_pkg::OP_REG: begin
        alu_op_o = rv_pkg::alu_op_e'({inst_q.r.funct7[5], inst_q.r.funct3});
        op1_o    = rs1_val_o;
        op2_o    = rs2_val_o;
        rd_we_o  = 1'b1;
      end
      default: begin
        illegal_o = 1'b1;
      end
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
module rv_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              raddr1_i,
  input  logic [4:0]              raddr2_i,
  output logic [rv_pkg::XLEN-1:0] rdata1_o,
  output logic [rv_pkg::XLEN-1:0] rdata2_o,
  input  logic                    we_i,
  input  logic [4:0]              waddr_i,
  input  logic [rv_pkg::XLEN-1:0] wdata_i
);

  // x0 has no storage.
  logic [rv_pkg::XLEN-1:0] regs_q [1:31];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata1_o = (raddr1_i == 5'd0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == 5'd0) ? '0 : regs_q[raddr2_i];

endmodule

// ==== rv_execute.sv ====
module rv_execute (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    e_load_i,
  input  rv_pkg::alu_op_e         alu_op_i,
  input  logic [rv_pkg::XLEN-1:0] op1_i,
  input  logic [rv_pkg::XLEN-1:0] op2_i,
  input  logic [rv_pkg::XLEN-1:0] rs1_val_i,
  input  logic [rv_pkg::XLEN-1:0] rs2_val_i,
  input  logic [rv_pkg::XLEN-1:0] imm_i,
  input  logic [rv_pkg::XLEN-1:0] tgt_base_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  input  logic [4:0]              rd_i,
  input  logic                    rd_we_i,
  input  logic                    is_branch_i,
  input  logic                    is_jump_i,
  input  logic                    illegal_i,
  input  logic [2:0]              funct3_i,
  output logic [rv_pkg::XLEN-1:0] res_o,
  output logic [rv_pkg::XLEN-1:0] next_pc_o,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic [4:0]              rd_o,
  output logic                    rd_we_o,
  output logic                    illegal_o
);

  logic [4:0]              shamt;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic [rv_pkg::XLEN-1:0] next_pc;
  logic                    taken;

  assign shamt = op2_i[4:0];

  //////////////////////////////
  // alu and branch compare.

  always_comb begin
    case (alu_op_i)
      rv_pkg::ALU_ADD:  alu_res = op1_i + op2_i;
      rv_pkg::ALU_SUB:  alu_res = op1_i - op2_i;
      rv_pkg::ALU_SLL:  alu_res = op1_i << shamt;
      rv_pkg::ALU_SLT:  alu_res = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
      rv_pkg::ALU_SLTU: alu_res = {{(rv_pkg::XLEN-1){1'b0}}, op1_i < op2_i};
      rv_pkg::ALU_XOR:  alu_res = op1_i ^ op2_i;
      rv_pkg::ALU_SRL:  alu_res = op1_i >> shamt;
      rv_pkg::ALU_SRA:  alu_res = $signed(op1_i) >>> shamt;
      rv_pkg::ALU_OR:   alu_res = op1_i | op2_i;
      rv_pkg::ALU_AND:  alu_res = op1_i & op2_i;
      default:          alu_res = '0;
    endcase
  end

  always_comb begin
    case (funct3_i)
      3'b000:  taken = rs1_val_i == rs2_val_i;
      3'b001:  taken = rs1_val_i != rs2_val_i;
      3'b100:  taken = $signed(rs1_val_i) < $signed(rs2_val_i);
      3'b101:  taken = $signed(rs1_val_i) >= $signed(rs2_val_i);
      3'b110:  taken = rs1_val_i < rs2_val_i;
      3'b111:  taken = rs1_val_i >= rs2_val_i;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    if (is_jump_i) begin
      next_pc = (tgt_base_i + imm_i) & ~32'd1;
    end else if (is_branch_i && taken) begin
      next_pc = pc_i + imm_i;
    end else begin
      next_pc = pc_i + 32'd4;
    end
  end

  //////////////////////////////
  // stage register, which doubles as the retire record.

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_we_o   <= 1'b0;
      illegal_o <= 1'b0;
    end else if (e_load_i) begin
      rd_we_o   <= rd_we_i;
      illegal_o <= illegal_i;
    end
  end

  always_ff @(posedge clk) begin
    if (e_load_i) begin
      res_o     <= alu_res;
      next_pc_o <= next_pc;
      pc_o      <= pc_i;
      rd_o      <= rd_i;
    end
  end

endmodule

// ==== rv_instret_counter.sv ====
module rv_instret_counter #(
  parameter int CNT_W = 32
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             retire_i,
  output logic [CNT_W-1:0] count_o
);

  // wraps to zero past the top of its width.
  always_ff @(posedge clk) begin
    if (rst) begin
      count_o <= '0;
    end else if (retire_i) begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

// ==== rv_exec_top.sv ====
module rv_exec_top #(
  parameter int CNT_W = 32
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    inst_valid_i,
  input  logic [31:0]             inst_i,
  input  logic [rv_pkg::XLEN-1:0] pc_i,
  output logic                    inst_ready_o,
  output logic                    ret_valid_o,
  input  logic                    ret_ready_i,
  output logic [rv_pkg::XLEN-1:0] ret_pc_o,
  output logic [4:0]              ret_rd_o,
  output logic                    ret_we_o,
  output logic [rv_pkg::XLEN-1:0] ret_data_o,
  output logic [rv_pkg::XLEN-1:0] ret_next_pc_o,
  output logic                    ret_illegal_o,
  output logic [CNT_W-1:0]        instret_o
);

  logic                    d_load;
  logic                    e_load;
  logic                    retire;
  logic [4:0]              rs1_addr;
  logic [4:0]              rs2_addr;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  rv_pkg::alu_op_e         alu_op;
  logic [rv_pkg::XLEN-1:0] op1;
  logic [rv_pkg::XLEN-1:0] op2;
  logic [rv_pkg::XLEN-1:0] rs1_val;
  logic [rv_pkg::XLEN-1:0] rs2_val;
  logic [rv_pkg::XLEN-1:0] imm;
  logic [rv_pkg::XLEN-1:0] tgt_base;
  logic [rv_pkg::XLEN-1:0] d_pc;
  logic [4:0]              rd;
  logic                    rd_we;
  logic                    is_branch;
  logic                    is_jump;
  logic                    illegal;
  logic [2:0]              funct3;

  rv_pipe_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid_i),
    .ret_ready_i  (ret_ready_i),
    .inst_ready_o (inst_ready_o),
    .d_load_o     (d_load),
    .e_load_o     (e_load),
    .d_valid_o    (),
    .e_valid_o    (ret_valid_o),
    .retire_o     (retire)
  );

  rv_decoder u_dec (
    .clk         (clk),
    .rst         (rst),
    .d_load_i    (d_load),
    .e_valid_i   (ret_valid_o),
    .inst_i      (inst_i),
    .pc_i        (pc_i),
    .rs1_data_i  (rs1_data),
    .rs2_data_i  (rs2_data),
    .rs1_addr_o  (rs1_addr),
    .rs2_addr_o  (rs2_addr),
    .fwd_rd_i    (ret_rd_o),
    .fwd_we_i    (ret_we_o),
    .fwd_data_i  (ret_data_o),
    .alu_op_o    (alu_op),
    .op1_o       (op1),
    .op2_o       (op2),
    .rs1_val_o   (rs1_val),
    .rs2_val_o   (rs2_val),
    .imm_o       (imm),
    .tgt_base_o  (tgt_base),
    .pc_o        (d_pc),
    .rd_o        (rd),
    .rd_we_o     (rd_we),
    .is_branch_o (is_branch),
    .is_jump_o   (is_jump),
    .illegal_o   (illegal),
    .funct3_o    (funct3)
  );

  // written back only when the retire transfer completes.
  rv_regfile u_rf (
    .clk      (clk),
    .rst      (rst),
    .raddr1_i (rs1_addr),
    .raddr2_i (rs2_addr),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data),
    .we_i     (retire & ret_we_o),
    .waddr_i  (ret_rd_o),
    .wdata_i  (ret_data_o)
  );

  rv_execute u_exe (
    .clk         (clk),
    .rst         (rst),
    .e_load_i    (e_load),
    .alu_op_i    (alu_op),
    .op1_i       (op1),
    .op2_i       (op2),
    .rs1_val_i   (rs1_val),
    .rs2_val_i   (rs2_val),
    .imm_i       (imm),
    .tgt_base_i  (tgt_base),
    .pc_i        (d_pc),
    .rd_i        (rd),
    .rd_we_i     (rd_we),
    .is_branch_i (is_branch),
    .is_jump_i   (is_jump),
    .illegal_i   (illegal),
    .funct3_i    (funct3),
    .res_o       (ret_data_o),
    .next_pc_o   (ret_next_pc_o),
    .pc_o        (ret_pc_o),
    .rd_o        (ret_rd_o),
    .rd_we_o     (ret_we_o),
    .illegal_o   (ret_illegal_o)
  );

  rv_instret_counter #(
    .CNT_W (CNT_W)
  ) u_cnt (
    .clk      (clk),
    .rst      (rst),
    .retire_i (retire),
    .count_o  (instret_o)
  );

endmodule

// ==== tb_rv_exec_assert.sv ====
module rv_exec_assert #(
  parameter int CNT_W = 32
) (
  input logic             clk,
  input logic             rst,
  input logic             ret_valid_i,
  input logic             ret_ready_i,
  input logic [31:0]      ret_pc_i,
  input logic [4:0]       ret_rd_i,
  input logic             ret_we_i,
  input logic [31:0]      ret_data_i,
  input logic [31:0]      ret_next_pc_i,
  input logic             ret_illegal_i,
  input logic [CNT_W-1:0] instret_i
);

  int err_cnt = 0;

  // the retire record holds while the consumer stalls.
  hold_chk: assert property (@(posedge clk) disable iff (rst)
    ret_valid_i && !ret_ready_i |=> ret_valid_i && $stable(ret_pc_i) && $stable(ret_rd_i) &&
      $stable(ret_we_i) && $stable(ret_data_i) && $stable(ret_next_pc_i) &&
      $stable(ret_illegal_i))
    else begin
      err_cnt++;
      $error("retire record changed while ret_ready_i was low");
    end

  reset_chk: assert property (@(posedge clk) rst |=> !ret_valid_i)
    else begin
      err_cnt++;
      $error("ret_valid_o high in the cycle after reset");
    end

  count_up_chk: assert property (@(posedge clk) disable iff (rst)
    ret_valid_i && ret_ready_i |=> instret_i == $past(instret_i) + CNT_W'(1))
    else begin
      err_cnt++;
      $error("instret_o did not advance by one on a retire");
    end

  count_hold_chk: assert property (@(posedge clk) disable iff (rst)
    !(ret_valid_i && ret_ready_i) |=> $stable(instret_i))
    else begin
      err_cnt++;
      $error("instret_o changed without a retire");
    end

  illegal_chk: assert property (@(posedge clk) disable iff (rst)
    ret_valid_i && ret_illegal_i |-> !ret_we_i)
    else begin
      err_cnt++;
      $error("illegal instruction retired with a register write");
    end

endmodule

bind rv_exec_top rv_exec_assert #(
  .CNT_W (CNT_W)
) u_chk (
  .clk           (clk),
  .rst           (rst),
  .ret_valid_i   (ret_valid_o),
  .ret_ready_i   (ret_ready_i),
  .ret_pc_i      (ret_pc_o),
  .ret_rd_i      (ret_rd_o),
  .ret_we_i      (ret_we_o),
  .ret_data_i    (ret_data_o),
  .ret_next_pc_i (ret_next_pc_o),
  .ret_illegal_i (ret_illegal_o),
  .instret_i     (instret_o)
);

// ==== tb_rv_exec.sv ====
module tb_rv_exec;

  localparam int N_INST   = 300;
  localparam int N_STEADY = 40;
  localparam int CNT_W    = 32;

  logic              clk = 1'b0;
  logic              rst;
  logic              inst_valid;
  logic [31:0]       inst;
  logic [31:0]       pc;
  logic              ret_ready;
  logic              inst_ready;
  logic              ret_valid;
  logic [31:0]       ret_pc;
  logic [4:0]        ret_rd;
  logic              ret_we;
  logic [31:0]       ret_data;
  logic [31:0]       ret_next_pc;
  logic              ret_illegal;
  logic [CNT_W-1:0]  instret;

  logic [31:0]  seed = 32'd42;
  logic [31:0]  regs [0:7];
  logic [102:0] exp_q [$];
  logic [102:0] cur_rec;
  logic [31:0]  gen_word;
  logic [31:0]  pc_gen = 32'h0000_1000;
  int           n_gen = 0;
  int           n_ret = 0;
  logic         accepted;
  logic         acc_d = 1'b0;
  logic [31:0]  acc_pc_d;
  logic         lat_chk = 1'b0;
  logic [31:0]  lat_pc;

  rv_exec_top #(
    .CNT_W (CNT_W)
  ) uut (
    .clk           (clk),
    .rst           (rst),
    .inst_valid_i  (inst_valid),
    .inst_i        (inst),
    .pc_i          (pc),
    .inst_ready_o  (inst_ready),
    .ret_valid_o   (ret_valid),
    .ret_ready_i   (ret_ready),
    .ret_pc_o      (ret_pc),
    .ret_rd_o      (ret_rd),
    .ret_we_o      (ret_we),
    .ret_data_o    (ret_data),
    .ret_next_pc_o (ret_next_pc),
    .ret_illegal_o (ret_illegal),
    .instret_o     (instret)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {8'd0, seed[31:8]};
  endfunction

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("ERR %s got %h expected %h", name, got, want);
    stop_with_failure();
  endtask

  //////////////////////////////
  // reference model

  function automatic logic [31:0] alu_model(logic alt, logic [2:0] f3, logic [31:0] a,
                                            logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // encodes one random instruction and works out its retire record.
  task automatic make_inst();
    logic [31:0] r;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] npc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic        we;
    logic        ill;
    r   = next_rand();
    imm = next_rand();
    rd  = 5'(r[2:0]);
    rs1 = 5'(r[5:3]);
    rs2 = 5'(r[8:6]);
    f3  = r[11:9];
    alt = r[12];
    a   = regs[rs1[2:0]];
    b   = regs[rs2[2:0]];
    we  = 1'b1;
    ill = 1'b0;
    res = 32'd0;
    npc = pc_gen + 32'd4;
    case (r[23:20])
      4'd0, 4'd1, 4'd2, 4'd3: begin
        if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0;
        gen_word = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, rv_pkg::OP_REG};
        res      = alu_model(alt, f3, a, b);
      end
      4'd4, 4'd5, 4'd6, 4'd7: begin
        if (f3 == 3'd1) imm[11:5] = 7'd0;
        if (f3 == 3'd5) imm[11:5] = {1'b0, alt, 5'd0};
        gen_word = {imm[11:0], rs1, f3, rd, rv_pkg::OP_IMM};
        res      = alu_model(f3 == 3'd5 && imm[10], f3, a, {{20{imm[11]}}, imm[11:0]});
      end
      4'd8: begin
        gen_word = {imm[19:0], rd, rv_pkg::OP_LUI};
        res      = {imm[19:0], 12'd0};
      end
      4'd9: begin
        gen_word = {imm[19:0], rd, rv_pkg::OP_AUIPC};
        res      = pc_gen + {imm[19:0], 12'd0};
      end
      4'd10, 4'd11, 4'd12: begin
        // funct3 values 2 and 3 are not branches, so they fold onto beq and bne.
        if (f3[2:1] == 2'b01) f3 = {2'b00, f3[0]};
        gen_word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
        we       = 1'b0;
        if (branch_taken(f3, a, b)) npc = pc_gen + {{19{imm[12]}}, imm[12:1], 1'b0};
      end
      4'd13: begin
        gen_word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
        res      = pc_gen + 32'd4;
        npc      = pc_gen + {{11{imm[20]}}, imm[20:1], 1'b0};
      end
      4'd14: begin
        gen_word = {imm[11:0], rs1, 3'b000, rd, rv_pkg::OP_JALR};
        res      = pc_gen + 32'd4;
        npc      = (a + {{20{imm[11]}}, imm[11:0]}) & ~32'd1;
      end
      default: begin
        gen_word = {imm[19:0], rd, alt ? 7'b1110011 : 7'b0000011};
        we       = 1'b0;
        ill      = 1'b1;
      end
    endcase
    cur_rec = {pc_gen, rd, we, res, npc, ill};
  endtask

  task automatic check_retire();
    logic [102:0] rec;
    logic [31:0]  e_pc;
    logic [31:0]  e_data;
    logic [31:0]  e_npc;
    logic [4:0]   e_rd;
    logic         e_we;
    logic         e_ill;
    if (exp_q.size() == 0) begin
      $display("an instruction retired that was never accepted");
      stop_with_failure();
    end else begin
      rec = exp_q.pop_front();
      {e_pc, e_rd, e_we, e_data, e_npc, e_ill} = rec;
      assert (ret_pc == e_pc) else report_mismatch("ret_pc_o", ret_pc, e_pc);
      assert (ret_we == e_we) else report_mismatch("ret_we_o", 32'(ret_we), 32'(e_we));
      assert (ret_illegal == e_ill)
        else report_mismatch("ret_illegal_o", 32'(ret_illegal), 32'(e_ill));
      assert (ret_next_pc == e_npc) else report_mismatch("ret_next_pc_o", ret_next_pc, e_npc);
      if (e_we) begin
        assert (ret_rd == e_rd) else report_mismatch("ret_rd_o", 32'(ret_rd), 32'(e_rd));
        assert (ret_data == e_data) else report_mismatch("ret_data_o", ret_data, e_data);
      end
    end
  endtask

  //////////////////////////////
  // stimulus and checks

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = 32'd0;
    pc         = 32'd0;
    ret_ready  = 1'b0;
    for (int i = 0; i < 8; i++) begin
      regs[i] = 32'd0;
    end
    repeat (2) @(posedge clk);
    rst       <= 1'b0;
    ret_ready <= 1'b1;
    while (n_ret < N_INST) begin
      @(posedge clk);
      if (uut.u_chk.err_cnt != 0) begin
        $display("a protocol assertion on the retire port failed");
        stop_with_failure();
      end
      accepted = inst_valid && inst_ready;
      if (accepted) begin
        exp_q.push_back(cur_rec);
        if (cur_rec[65] && cur_rec[66 +: 5] != 5'd0) regs[cur_rec[68:66]] = cur_rec[64:33];
      end
      if (ret_valid && ret_ready) begin
        check_retire();
        n_ret++;
      end
      // accepted two edges ago with the consumer ready, so it must sit in execute now.
      if (lat_chk) begin
        assert (ret_valid && ret_pc == lat_pc) else begin
          $display("instruction at pc %h did not reach the retire port after two edges",
                   lat_pc);
          stop_with_failure();
        end
      end
      lat_chk  = acc_d && ret_ready;
      lat_pc   = acc_pc_d;
      acc_d    = accepted;
      acc_pc_d = pc;
      if (n_gen >= N_STEADY) ret_ready <= (next_rand() >> 22) != 32'd0;
      if (inst_valid && !accepted) begin
        inst_valid <= 1'b1;
      end else if (n_gen < N_INST && (n_gen < N_STEADY || (next_rand() >> 22) != 32'd0)) begin
        make_inst();
        inst       <= gen_word;
        pc         <= pc_gen;
        inst_valid <= 1'b1;
        pc_gen      = pc_gen + 32'd4;
        n_gen++;
      end else begin
        inst_valid <= 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    assert (instret == CNT_W'(N_INST))
      else report_mismatch("instret_o", 32'(instret), 32'(N_INST));
    if (uut.u_chk.err_cnt == 0 && exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("protocol assertions failed or accepted instructions never retired");
      stop_with_failure();
    end
  end

  initial begin
    #(N_INST * 20 * 4);
    $display("timeout, the instructions did not all retire in time");
    stop_with_failure();
  end

endmodule

// ==== compile.f ====
rv_pkg.sv
rv_pipe_ctrl.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_instret_counter.sv
rv_exec_top.sv
tb_rv_exec_assert.sv
tb_rv_exec.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rv_exec -f compile.f -o sim_rv_exec
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_rv_exec +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "Test completed successfully" sim.log; then
  exit 0
fi
exit 1
